//--- src/vec_core_pkg.sv
`default_nettype none

package vec_core_pkg;

    // widths
    localparam int XLEN        = 32;
    localparam int INSTR_W     = 32;
    localparam int REG_IDX_W   = 5;
    localparam int RFADD_W     = 10;   // vector register file address
    localparam int VLEN_CODE_W = 3;    // chunk-size code from vsetivli
    localparam int BR_IMM_W    = 12;

    localparam logic [11:0] CSR_INSTRET = 12'hC00;

    // major opcodes
    localparam logic [6:0] OPC_VECT    = 7'h57;
    localparam logic [6:0] OPC_VLOAD   = 7'h07;
    localparam logic [6:0] OPC_VSTORE  = 7'h27;
    localparam logic [6:0] OPC_VSTREAM = 7'h7F;   // custom extension
    localparam logic [6:0] OPC_BRANCH  = 7'h63;
    localparam logic [6:0] OPC_OPIMM   = 7'h13;
    localparam logic [6:0] OPC_LUI     = 7'h37;
    localparam logic [6:0] OPC_OP      = 7'h33;
    localparam logic [6:0] OPC_LOAD    = 7'h03;   // carries the counter read
    localparam logic [6:0] OPC_SYSTEM  = 7'h73;

    // funct fields
    localparam logic [2:0] F3_VMACC    = 3'h0;
    localparam logic [2:0] F3_VMV      = 3'h5;
    localparam logic [2:0] F3_VSETIVLI = 3'h7;
    localparam logic [2:0] F3_BNE      = 3'h1;
    localparam logic [2:0] F3_ADDI     = 3'h0;
    localparam logic [2:0] F3_ADD      = 3'h0;
    localparam logic [6:0] F7_ADD      = 7'h00;

    // wfi: funct12 105h, rs1 x0, rd x0
    localparam logic [31:0] WFI_WORD = {12'h105, 5'd0, 3'd0, 5'd0, OPC_SYSTEM};

    typedef enum logic [2:0] {
        S_NOP,
        S_LUI,
        S_ADDI,
        S_ADD,
        S_BNE,
        S_CSR
    } scalar_op_e;

    typedef enum logic [2:0] {
        V_NOP,
        V_VLE32,
        V_VSE32,
        V_VMACC,
        V_VMV,
        V_VSTREAM,
        V_VSETIVLI
    } vector_op_e;

endpackage

`default_nettype wire

//--- src/isa_decoder.sv
`default_nettype none

module isa_decoder (
    input  logic [vec_core_pkg::INSTR_W-1:0]     instr,
    input  logic                                 instr_valid,
    output vec_core_pkg::scalar_op_e             s_op,
    output vec_core_pkg::vector_op_e             v_op,
    output logic [vec_core_pkg::REG_IDX_W-1:0]   rs1,
    output logic [vec_core_pkg::REG_IDX_W-1:0]   rs2,
    output logic [vec_core_pkg::REG_IDX_W-1:0]   rd,
    output logic [vec_core_pkg::REG_IDX_W-1:0]   vs2,
    output logic [vec_core_pkg::REG_IDX_W-1:0]   vd,
    output logic [vec_core_pkg::XLEN-1:0]        imm,
    output logic [vec_core_pkg::BR_IMM_W-1:0]    br_imm,
    output logic [vec_core_pkg::VLEN_CODE_W-1:0] vl_code,
    output logic                                 is_wfi
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    logic is_lui;
    logic is_addi;
    logic is_add;
    logic is_bne;
    logic is_csr;
    logic is_vle32;
    logic is_vse32;
    logic is_vmacc;
    logic is_vmv;
    logic is_vstream;
    logic is_vsetivli;

    logic [vec_core_pkg::XLEN-1:0] lui_imm;
    logic [vec_core_pkg::XLEN-1:0] addi_imm;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // scalar matches
    assign is_lui  = (opcode == vec_core_pkg::OPC_LUI);
    assign is_addi = (opcode == vec_core_pkg::OPC_OPIMM) && (funct3 == vec_core_pkg::F3_ADDI);
    assign is_add  = (opcode == vec_core_pkg::OPC_OP) && (funct3 == vec_core_pkg::F3_ADD)
                     && (funct7 == vec_core_pkg::F7_ADD);
    assign is_bne  = (opcode == vec_core_pkg::OPC_BRANCH) && (funct3 == vec_core_pkg::F3_BNE);
    assign is_csr  = (opcode == vec_core_pkg::OPC_LOAD)
                     && (instr[31:20] == vec_core_pkg::CSR_INSTRET);

    // vector matches
    assign is_vle32    = (opcode == vec_core_pkg::OPC_VLOAD);
    assign is_vse32    = (opcode == vec_core_pkg::OPC_VSTORE);
    assign is_vstream  = (opcode == vec_core_pkg::OPC_VSTREAM);
    assign is_vmacc    = (opcode == vec_core_pkg::OPC_VECT) && (funct3 == vec_core_pkg::F3_VMACC);
    assign is_vmv      = (opcode == vec_core_pkg::OPC_VECT) && (funct3 == vec_core_pkg::F3_VMV);
    assign is_vsetivli = (opcode == vec_core_pkg::OPC_VECT)
                         && (funct3 == vec_core_pkg::F3_VSETIVLI);

    assign is_wfi = (instr == vec_core_pkg::WFI_WORD);

    // one scalar and one vector op per word, nop when idle
    always_comb begin
        s_op = vec_core_pkg::S_NOP;
        if (instr_valid) begin
            if (is_lui)
                s_op = vec_core_pkg::S_LUI;
            else if (is_addi)
                s_op = vec_core_pkg::S_ADDI;
            else if (is_add)
                s_op = vec_core_pkg::S_ADD;
            else if (is_bne)
                s_op = vec_core_pkg::S_BNE;
            else if (is_csr)
                s_op = vec_core_pkg::S_CSR;
        end
    end

    always_comb begin
        v_op = vec_core_pkg::V_NOP;
        if (instr_valid) begin
            if (is_vle32)
                v_op = vec_core_pkg::V_VLE32;
            else if (is_vse32)
                v_op = vec_core_pkg::V_VSE32;
            else if (is_vmacc)
                v_op = vec_core_pkg::V_VMACC;
            else if (is_vmv)
                v_op = vec_core_pkg::V_VMV;
            else if (is_vstream)
                v_op = vec_core_pkg::V_VSTREAM;
            else if (is_vsetivli)
                v_op = vec_core_pkg::V_VSETIVLI;
        end
    end

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    assign lui_imm  = {instr[31:12], 12'd0};
    assign addi_imm = {{20{instr[31]}}, instr[31:20]};
    assign imm      = is_addi ? addi_imm : lui_imm;

    // branch immediate, kept in the bit order of the existing decoder
    assign br_imm = {instr[31], instr[7], instr[30:25], instr[11:8]};

    // stores and streamout read the register sitting in the rd slot
    assign vs2 = (is_vse32 || is_vstream) ? instr[11:7] : instr[24:20];
    assign vd  = instr[11:7];

    assign vl_code = instr[17:15];

endmodule

`default_nettype wire

//--- src/scalar_exec.sv
`default_nettype none

module scalar_exec (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               instr_valid,
    input  vec_core_pkg::scalar_op_e           s_op,
    input  logic [vec_core_pkg::REG_IDX_W-1:0] rs1,
    input  logic [vec_core_pkg::REG_IDX_W-1:0] rs2,
    input  logic [vec_core_pkg::REG_IDX_W-1:0] rd,
    input  logic [vec_core_pkg::XLEN-1:0]      imm,
    input  logic [vec_core_pkg::BR_IMM_W-1:0]  br_imm,
    output logic                               wb_en,
    output logic [vec_core_pkg::XLEN-1:0]      wb_data,
    output logic                               br_taken,
    output logic [vec_core_pkg::XLEN-1:0]      br_offset
);

    // x1..x31, x0 is hardwired
    logic [vec_core_pkg::XLEN-1:0] regs [1:31];

    logic [vec_core_pkg::XLEN-1:0] instret;   // valid words accepted so far
    logic [vec_core_pkg::XLEN-1:0] rs1_val;
    logic [vec_core_pkg::XLEN-1:0] rs2_val;

    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    always_comb begin
        wb_en   = 1'b1;
        wb_data = '0;
        case (s_op)
            vec_core_pkg::S_LUI: begin
                wb_data = imm;
            end
            vec_core_pkg::S_ADDI: begin
                wb_data = rs1_val + imm;   // imm already sign-extended
            end
            vec_core_pkg::S_ADD: begin
                wb_data = rs1_val + rs2_val;
            end
            vec_core_pkg::S_CSR: begin
                wb_data = instret;         // count before this word
            end
            default: begin
                wb_en = 1'b0;
            end
        endcase
    end

    // bne only reports, no redirect here
    assign br_taken  = (s_op == vec_core_pkg::S_BNE) && (rs1_val != rs2_val);
    assign br_offset = {{(vec_core_pkg::XLEN - vec_core_pkg::BR_IMM_W - 1){br_imm[11]}},
                        br_imm, 1'b0};

    always_ff @(posedge clk) begin
        if (wb_en && (rd != '0)) begin
            regs[rd] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instret <= '0;
        end else if (instr_valid) begin
            instret <= instret + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/vreg_addr_map.sv
`default_nettype none

module vreg_addr_map (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  vec_core_pkg::vector_op_e             v_op,
    input  logic [vec_core_pkg::VLEN_CODE_W-1:0] vl_code,
    input  logic [vec_core_pkg::REG_IDX_W-1:0]   vs2,
    input  logic [vec_core_pkg::REG_IDX_W-1:0]   vd,
    output logic [vec_core_pkg::RFADD_W-1:0]     vr_addr,
    output logic [vec_core_pkg::RFADD_W-1:0]     vw_addr
);

    logic [vec_core_pkg::VLEN_CODE_W-1:0] chunk_code;
    logic [vec_core_pkg::RFADD_W-1:0]     vr_base;

    // base address of a vector register for a given chunk code.
    // code k keeps the low k+1 index bits (all 5 from k=4 on) and
    // places them so that the lowest kept bit lands on bit RFADD_W-1-k
    function automatic logic [vec_core_pkg::RFADD_W-1:0] base_addr(
        input logic [vec_core_pkg::REG_IDX_W-1:0]   idx,
        input logic [vec_core_pkg::VLEN_CODE_W-1:0] code
    );
        logic [vec_core_pkg::REG_IDX_W-1:0] mask;
        logic [vec_core_pkg::RFADD_W-1:0]   wide;
        mask = ~({vec_core_pkg::REG_IDX_W{1'b1}} << (int'(code) + 1));
        wide = {{(vec_core_pkg::RFADD_W - vec_core_pkg::REG_IDX_W){1'b0}}, idx & mask};
        return wide << (vec_core_pkg::RFADD_W - 1 - int'(code));
    endfunction

    // chunk code from vsetivli, v_op is already qualified by valid
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chunk_code <= '0;
        end else if (v_op == vec_core_pkg::V_VSETIVLI) begin
            chunk_code <= vl_code;
        end
    end

    assign vr_base = base_addr(vs2, chunk_code);

    // vmacc operands always live in the first group
    assign vr_addr = (v_op == vec_core_pkg::V_VMACC)
                     ? {{(vec_core_pkg::RFADD_W - vec_core_pkg::REG_IDX_W){1'b0}}, vs2}
                     : vr_base;
    assign vw_addr = base_addr(vd, chunk_code);

endmodule

`default_nettype wire

//--- src/result_stage.sv
`default_nettype none

module result_stage (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               instr_valid,
    input  vec_core_pkg::scalar_op_e           s_op,
    input  vec_core_pkg::vector_op_e           v_op,
    input  logic [vec_core_pkg::REG_IDX_W-1:0] rd,
    input  logic                               wb_en,
    input  logic [vec_core_pkg::XLEN-1:0]      wb_data,
    input  logic                               br_taken,
    input  logic [vec_core_pkg::XLEN-1:0]      br_offset,
    input  logic [vec_core_pkg::RFADD_W-1:0]   vr_addr,
    input  logic [vec_core_pkg::RFADD_W-1:0]   vw_addr,
    input  logic                               is_wfi,
    input  logic                               done_steady,
    output logic                               wb_valid,
    output logic [vec_core_pkg::REG_IDX_W-1:0] wb_rd,
    output logic [vec_core_pkg::XLEN-1:0]      wb_data_q,
    output logic                               br_valid,
    output logic                               br_taken_q,
    output logic [vec_core_pkg::XLEN-1:0]      br_offset_q,
    output logic                               vec_valid,
    output vec_core_pkg::vector_op_e           vec_op,
    output logic [vec_core_pkg::RFADD_W-1:0]   vr_addr_q,
    output logic [vec_core_pkg::RFADD_W-1:0]   vw_addr_q,
    output logic                               done
);

    logic vec_issue;

    // vsetivli only reconfigures the mapping
    assign vec_issue = (v_op != vec_core_pkg::V_NOP) && (v_op != vec_core_pkg::V_VSETIVLI);

    // strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid  <= 1'b0;
            br_valid  <= 1'b0;
            vec_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            wb_valid  <= wb_en;
            br_valid  <= (s_op == vec_core_pkg::S_BNE);
            vec_valid <= vec_issue;
            done      <= instr_valid && is_wfi && done_steady;   // one pulse per steady wfi
        end
    end

    // payload, only meaningful with its strobe
    always_ff @(posedge clk) begin
        wb_rd       <= rd;
        wb_data_q   <= wb_data;
        br_taken_q  <= br_taken;
        br_offset_q <= br_offset;
        vec_op      <= v_op;
        vr_addr_q   <= vr_addr;
        vw_addr_q   <= vw_addr;
    end

endmodule

`default_nettype wire

//--- src/vec_core_top.sv
`default_nettype none

module vec_core_top (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [vec_core_pkg::INSTR_W-1:0]   instr,
    input  logic                               instr_valid,
    input  logic                               done_steady,
    output logic                               wb_valid,
    output logic [vec_core_pkg::REG_IDX_W-1:0] wb_rd,
    output logic [vec_core_pkg::XLEN-1:0]      wb_data,
    output logic                               br_valid,
    output logic                               br_taken,
    output logic [vec_core_pkg::XLEN-1:0]      br_offset,
    output logic                               vec_valid,
    output vec_core_pkg::vector_op_e           vec_op,
    output logic [vec_core_pkg::RFADD_W-1:0]   vr_addr,
    output logic [vec_core_pkg::RFADD_W-1:0]   vw_addr,
    output logic                               done
);

    vec_core_pkg::scalar_op_e             s_op;
    vec_core_pkg::vector_op_e             v_op;
    logic [vec_core_pkg::REG_IDX_W-1:0]   rs1;
    logic [vec_core_pkg::REG_IDX_W-1:0]   rs2;
    logic [vec_core_pkg::REG_IDX_W-1:0]   rd;
    logic [vec_core_pkg::REG_IDX_W-1:0]   vs2;
    logic [vec_core_pkg::REG_IDX_W-1:0]   vd;
    logic [vec_core_pkg::XLEN-1:0]        imm;
    logic [vec_core_pkg::BR_IMM_W-1:0]    br_imm;
    logic [vec_core_pkg::VLEN_CODE_W-1:0] vl_code;
    logic                                 is_wfi;

    // execute results, registered in the result stage
    logic                               ex_wb_en;
    logic [vec_core_pkg::XLEN-1:0]      ex_wb_data;
    logic                               ex_br_taken;
    logic [vec_core_pkg::XLEN-1:0]      ex_br_offset;
    logic [vec_core_pkg::RFADD_W-1:0]   ex_vr_addr;
    logic [vec_core_pkg::RFADD_W-1:0]   ex_vw_addr;

    isa_decoder i_isa_decoder (
        .instr       (instr),
        .instr_valid (instr_valid),
        .s_op        (s_op),
        .v_op        (v_op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .vs2         (vs2),
        .vd          (vd),
        .imm         (imm),
        .br_imm      (br_imm),
        .vl_code     (vl_code),
        .is_wfi      (is_wfi)
    );

    scalar_exec i_scalar_exec (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .s_op        (s_op),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .br_imm      (br_imm),
        .wb_en       (ex_wb_en),
        .wb_data     (ex_wb_data),
        .br_taken    (ex_br_taken),
        .br_offset   (ex_br_offset)
    );

    vreg_addr_map i_vreg_addr_map (
        .clk     (clk),
        .arst_n  (arst_n),
        .v_op    (v_op),
        .vl_code (vl_code),
        .vs2     (vs2),
        .vd      (vd),
        .vr_addr (ex_vr_addr),
        .vw_addr (ex_vw_addr)
    );

    result_stage i_result_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .s_op        (s_op),
        .v_op        (v_op),
        .rd          (rd),
        .wb_en       (ex_wb_en),
        .wb_data     (ex_wb_data),
        .br_taken    (ex_br_taken),
        .br_offset   (ex_br_offset),
        .vr_addr     (ex_vr_addr),
        .vw_addr     (ex_vw_addr),
        .is_wfi      (is_wfi),
        .done_steady (done_steady),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data_q   (wb_data),
        .br_valid    (br_valid),
        .br_taken_q  (br_taken),
        .br_offset_q (br_offset),
        .vec_valid   (vec_valid),
        .vec_op      (vec_op),
        .vr_addr_q   (vr_addr),
        .vw_addr_q   (vw_addr),
        .done        (done)
    );

endmodule

`default_nettype wire

//--- tests/vec_core_tb.sv
`default_nettype none

module vec_core_tb;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_ROWS   = 64;

    // expected output kind, low nibble of the control word
    localparam logic [3:0] K_NONE = 4'd0;
    localparam logic [3:0] K_WB   = 4'd1;
    localparam logic [3:0] K_BR   = 4'd2;
    localparam logic [3:0] K_VEC  = 4'd3;
    localparam logic [3:0] K_DONE = 4'd4;

    logic        clk;
    logic        arst_n;
    logic [31:0] instr;
    logic        instr_valid;
    logic        done_steady;

    logic                     wb_valid;
    logic [4:0]               wb_rd;
    logic [31:0]              wb_data;
    logic                     br_valid;
    logic                     br_taken;
    logic [31:0]              br_offset;
    logic                     vec_valid;
    vec_core_pkg::vector_op_e vec_op;
    logic [9:0]               vr_addr;
    logic [9:0]               vw_addr;
    logic                     done;

    logic [31:0] patterns [0:4*MAX_ROWS-1];   // instr, ctrl, exp_a, exp_b per row
    int          n_rows;

    vec_core_top i_vec_core_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .done_steady (done_steady),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .br_valid    (br_valid),
        .br_taken    (br_taken),
        .br_offset   (br_offset),
        .vec_valid   (vec_valid),
        .vec_op      (vec_op),
        .vr_addr     (vr_addr),
        .vw_addr     (vw_addr),
        .done        (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic string mismatch_line(input string name, input string field,
                                            input logic [31:0] exp_val,
                                            input logic [31:0] act_val);
        return $sformatf("Mismatch %s %s expected 0x%08h actual 0x%08h",
                         name, field, exp_val, act_val);
    endfunction

    function automatic string group_name(input logic [3:0] grp);
        case (grp)
            4'd1:    return "writeback";
            4'd2:    return "branch";
            4'd3:    return "vector_map";
            4'd4:    return "counter";
            4'd5:    return "done";
            default: return "misc";
        endcase
    endfunction

    // {wb_valid, br_valid, vec_valid, done}
    function automatic logic [3:0] strobes_for(input logic [3:0] kind);
        case (kind)
            K_WB:    return 4'b1000;
            K_BR:    return 4'b0100;
            K_VEC:   return 4'b0010;
            K_DONE:  return 4'b0001;
            default: return 4'b0000;
        endcase
    endfunction

    task automatic drive_row(input int r);
        instr       = patterns[4*r];
        instr_valid = patterns[4*r+1][8];
        done_steady = patterns[4*r+1][4];
    endtask

    task automatic check_row(input int r);
        logic [31:0] ctrl;
        logic [31:0] exp_a;
        logic [31:0] exp_b;
        logic [3:0]  kind;
        logic [3:0]  got_strb;
        string       name;
        ctrl     = patterns[4*r+1];
        exp_a    = patterns[4*r+2];
        exp_b    = patterns[4*r+3];
        kind     = ctrl[3:0];
        got_strb = {wb_valid, br_valid, vec_valid, done};
        name     = $sformatf("%s_row%0d", group_name(ctrl[15:12]), r);
        if (kind == K_NONE) begin
            assert (got_strb == 4'b0000) else
                stop_run($sformatf("%s expects no output, but strobes wb/br/vec/done are %b",
                                   name, got_strb));
        end else begin
            assert (got_strb == strobes_for(kind)) else
                stop_run(mismatch_line(name, "strobes", {28'd0, strobes_for(kind)},
                                       {28'd0, got_strb}));
        end
        case (kind)
            K_WB: begin
                assert (wb_data == exp_a) else
                    stop_run(mismatch_line(name, "wb_data", exp_a, wb_data));
                assert (wb_rd == exp_b[4:0]) else
                    stop_run(mismatch_line(name, "wb_rd", exp_b, {27'd0, wb_rd}));
            end
            K_BR: begin
                assert (br_taken == exp_a[0]) else
                    stop_run(mismatch_line(name, "br_taken", exp_a, {31'd0, br_taken}));
                assert (br_offset == exp_b) else
                    stop_run(mismatch_line(name, "br_offset", exp_b, br_offset));
            end
            K_VEC: begin
                assert (vec_op == exp_a[2:0]) else
                    stop_run(mismatch_line(name, "vec_op", exp_a, {29'd0, vec_op}));
                assert ({6'd0, vr_addr, 6'd0, vw_addr} == exp_b) else
                    stop_run(mismatch_line(name, "vr/vw addr", exp_b,
                                           {6'd0, vr_addr, 6'd0, vw_addr}));
            end
            default: ;
        endcase
    endtask

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        done_steady = 1'b0;
        // unused words keep a nonzero top half, which ends the row count
        for (int a = 0; a < 4*MAX_ROWS; a++) begin
            patterns[a] = ~32'(a);
        end
        $readmemh("tests/vec_core_patterns.hex", patterns);
        n_rows = 0;
        while ((n_rows < MAX_ROWS) && (patterns[4*n_rows+1][31:16] == 16'h0000)) begin
            n_rows++;
        end
        if (n_rows == 0) begin
            stop_run("no pattern rows found in tests/vec_core_patterns.hex");
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            @(negedge clk);
            if (r > 0) begin
                check_row(r - 1);   // outputs of the word taken at the last edge
            end
            drive_row(r);
        end
        @(negedge clk);
        check_row(n_rows - 1);
        instr_valid = 1'b0;
        $display("TEST RESULT: PASS");
        $finish;
    end

    // watchdog, rows plus reset and some slack
    initial begin
        #1;
        #((n_rows + 10) * CLK_PERIOD);
        stop_run("watchdog expired before all pattern rows were checked");
    end

endmodule

`default_nettype wire

//--- tests/vec_core_patterns.hex
// instr, ctrl {group, valid, done_steady, kind} in nibbles 15:0, exp_a, exp_b
// kind 0 none, 1 wb (data, rd), 2 bne (taken, offset), 3 vector (op, vr<<16|vw), 4 done
123450B7 00001101 12345000 00000001
FF008113 00001101 12344FF0 00000002
002081B3 00001101 24689FF0 00000003
00508013 00001101 12345005 00000000
00100233 00001101 12345000 00000004
FE209CE3 00002102 00000001 FFFFFFF8
00409863 00002102 00000000 00000010
00007057 00003100 00000000 00000000
00000187 00003103 00000001 00000200
000002A7 00003103 00000002 02000200
0001F057 00003100 00000000 00000000
00600687 00003103 00000001 01800340
016004D7 00003103 00000003 00160240
00037057 00003100 00000000 00000000
000009A7 00003103 00000002 00980098
00100F87 00003103 00000001 000800F8
0000017F 00003103 00000005 00100010
123450B7 00004000 00000000 00000000
C0000283 00004000 00000000 00000000
C0000283 00004101 00000011 00000005
00000000 00004000 00000000 00000000
C0000303 00004101 00000012 00000006
10500073 00005100 00000000 00000000
10500073 00005114 00000000 00000000
0000000B 00005100 00000000 00000000
7C009073 00005100 00000000 00000000
C0000383 00004101 00000017 00000007

//--- build.f
src/vec_core_pkg.sv
src/isa_decoder.sv
src/scalar_exec.sv
src/vreg_addr_map.sv
src/result_stage.sv
src/vec_core_top.sv
tests/vec_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= vec_core_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the simulation prints the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
